// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= frontEndTb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS ?= --timing --assert --timescale $(TIMESCALE)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/isaPkg.sv ====
`default_nettype none

package isaPkg;

    // ********************
    // architectural state
    // ********************
    localparam int ARCH_REGS = 8;

    typedef logic [$clog2(ARCH_REGS)-1:0] archReg;

    // ********************
    // instruction format
    // ********************
    typedef logic [15:0] instrWord;

    // field view of an instrWord, msb first
    typedef struct packed {
        logic [3:0] opcode;
        archReg     rd;
        archReg     rs1;
        archReg     rs2;
        logic [2:0] spare;  // unused bits
    } instrFields;

    // opcode field values 0 to 5 line up with the first six enum values
    typedef enum logic [2:0] {
        add     = 3'd0,
        sub     = 3'd1,
        andOp   = 3'd2,
        orOp    = 3'd3,
        loadImm = 3'd4,
        nop     = 3'd5,
        illegal = 3'd6
    } opKind;

    // highest opcode field value that decodes to a real op
    localparam logic [3:0] LAST_OPCODE = 4'd5;

endpackage

`default_nettype wire

// ==== common/pipePkg.sv ====
`default_nettype none

package pipePkg;

    // ********************
    // machine sizes
    // ********************
    localparam int MACHINE_WIDTH = 2;
    localparam int PHYS_REGS = 16;

    // tags above the reset mapping start out free
    localparam int FIRST_FREE = isaPkg::ARCH_REGS;
    localparam int INIT_FREE = PHYS_REGS - FIRST_FREE;

    typedef logic [$clog2(PHYS_REGS)-1:0] physTag;

    // ********************
    // bundles between stages
    // ********************
    typedef struct packed {
        isaPkg::instrWord [MACHINE_WIDTH-1:0] instr;
        logic [MACHINE_WIDTH-1:0]             mask;  // one bit per slot
    } rawBundle;

    typedef struct packed {
        logic           valid;
        isaPkg::opKind  op;
        logic           writesDest;
        isaPkg::archReg rd;
        isaPkg::archReg rs1;
        isaPkg::archReg rs2;
    } decodedSlot;

    typedef decodedSlot [MACHINE_WIDTH-1:0] decodedBundle;

    typedef struct packed {
        logic          valid;
        isaPkg::opKind op;
        physTag        pd;   // zero when the slot writes nothing
        physTag        ps1;
        physTag        ps2;
    } renamedSlot;

    typedef renamedSlot [MACHINE_WIDTH-1:0] renamedBundle;

endpackage

`default_nettype wire

// ==== flist.f ====
common/isaPkg.sv
common/pipePkg.sv
logic/pipeStage.sv
logic/decodeUnit.sv
rename/renameMap.sv
rename/freeList.sv
logic/frontEnd.sv
verif/frontEndTb.sv

// ==== logic/decodeUnit.sv ====
`timescale 1ns/100ps
`default_nettype none

module decodeUnit (
    input  pipePkg::rawBundle     bundle,
    output pipePkg::decodedBundle decoded
);
    import isaPkg::*;
    import pipePkg::*;

    instrFields [MACHINE_WIDTH-1:0] fields;

    assign fields = bundle.instr;  // same bits, field view

    function automatic opKind decodeOp(logic [3:0] code);
        if (code <= LAST_OPCODE) begin
            return opKind'(code[2:0]);
        end
        return illegal;
    endfunction

    // ********************
    // per slot decode
    // ********************
    always_comb begin
        for (int i = 0; i < MACHINE_WIDTH; i++) begin
            decoded[i].valid = bundle.mask[i];
            decoded[i].op = decodeOp(fields[i].opcode);
            decoded[i].rd = fields[i].rd;
            decoded[i].rs1 = fields[i].rs1;
            decoded[i].rs2 = fields[i].rs2;
            // nop and illegal leave the register file alone
            decoded[i].writesDest = decoded[i].op inside {add, sub, andOp, orOp, loadImm};
        end
    end

endmodule

`default_nettype wire

// ==== logic/frontEnd.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontEnd (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  flush,
    input  logic                  inValid,
    input  pipePkg::rawBundle     inBundle,
    output logic                  inReady,
    output logic                  outValid,
    output pipePkg::renamedBundle outBundle,
    input  logic                  outReady,
    input  logic                  relValid,
    input  pipePkg::physTag       relTag
);
    import pipePkg::*;

    decodedBundle decoded, stage1Data;
    logic stage1Valid, renReady;
    renamedBundle renamed;
    logic renValid, stage2Ready;
    logic [$clog2(PHYS_REGS):0] freeCount;
    physTag freeHead0, freeHead1;
    logic [1:0] popCount;

    decodeUnit decoder (
        .bundle  (inBundle),
        .decoded (decoded)
    );

    // ********************
    // decode to rename
    // ********************
    pipeStage #(.payloadType(decodedBundle)) stage1 (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .upValid   (inValid),
        .upData    (decoded),
        .upReady   (inReady),
        .downValid (stage1Valid),
        .downData  (stage1Data),
        .downReady (renReady)
    );

    renameMap renamer (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (stage1Valid),
        .inBundle  (stage1Data),
        .inReady   (renReady),
        .outValid  (renValid),
        .outBundle (renamed),
        .outReady  (stage2Ready),
        .freeCount (freeCount),
        .freeHead0 (freeHead0),
        .freeHead1 (freeHead1),
        .popCount  (popCount)
    );

    freeList freeTags (
        .clk       (clk),
        .rstN      (rstN),
        .popCount  (popCount),
        .pushValid (relValid),
        .pushTag   (relTag),
        .count     (freeCount),
        .head0     (freeHead0),
        .head1     (freeHead1)
    );

    // ********************
    // rename to output
    // ********************
    // renamed bundles cannot be undone, so flush stops at stage1
    pipeStage #(.payloadType(renamedBundle)) stage2 (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (1'b0),
        .upValid   (renValid),
        .upData    (renamed),
        .upReady   (stage2Ready),
        .downValid (outValid),
        .downData  (outBundle),
        .downReady (outReady)
    );

endmodule

`default_nettype wire

// ==== logic/pipeStage.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipeStage #(
    parameter type payloadType = logic
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       flush,
    input  logic       upValid,
    input  payloadType upData,
    output logic       upReady,
    output logic       downValid,
    output payloadType downData,
    input  logic       downReady
);
    logic       full;
    payloadType held;

    // a flushed stage takes nothing on that edge
    assign upReady = (!full || downReady) && !flush;
    assign downValid = full;
    assign downData = held;

    // ********************
    // stage register
    // ********************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            full <= 1'b0;
            held <= '0;
        end else if (flush) begin
            full <= 1'b0;
        end else if (upValid && upReady) begin
            full <= 1'b1;
            held <= upData;
        end else if (downReady) begin
            full <= 1'b0;  // drained with nothing behind it
        end
    end

    // a stalled consumer must see the same payload on the next edge
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        downValid && !downReady |=> $stable(downData));

endmodule

`default_nettype wire

// ==== rename/freeList.sv ====
`timescale 1ns/100ps
`default_nettype none

module freeList (
    input  logic                                clk,
    input  logic                                rstN,
    input  logic [1:0]                          popCount,
    input  logic                                pushValid,
    input  pipePkg::physTag                     pushTag,
    output logic [$clog2(pipePkg::PHYS_REGS):0] count,
    output pipePkg::physTag                     head0,
    output pipePkg::physTag                     head1
);
    import pipePkg::*;

    physTag fifo [PHYS_REGS];
    logic [$clog2(PHYS_REGS)-1:0] rdPtr, wrPtr, rdPtr1;

    assign rdPtr1 = rdPtr + 1'b1;  // wraps with the ring
    assign head0 = fifo[rdPtr];
    assign head1 = fifo[rdPtr1];

    // ********************
    // pointers and count
    // ********************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= ($clog2(PHYS_REGS))'(INIT_FREE);
            count <= ($clog2(PHYS_REGS) + 1)'(INIT_FREE);
        end else begin
            rdPtr <= rdPtr + ($clog2(PHYS_REGS))'(popCount);
            if (pushValid) begin
                wrPtr <= wrPtr + 1'b1;
            end
            count <= count + ($clog2(PHYS_REGS) + 1)'(pushValid)
                           - ($clog2(PHYS_REGS) + 1)'(popCount);
        end
    end

    // ********************
    // tag storage
    // ********************
    // reset contents are the free tags, entries past INIT_FREE hold don't care values
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                fifo[i] <= physTag'(i + FIRST_FREE);
            end
        end else if (pushValid) begin
            fifo[wrPtr] <= pushTag;  // released tags go to the tail
        end
    end

    noUnderflow: assert property (@(posedge clk) disable iff (!rstN)
        popCount <= count);

    // a full list means a tag was released twice
    noOverflow: assert property (@(posedge clk) disable iff (!rstN)
        pushValid |-> count < ($clog2(PHYS_REGS) + 1)'(PHYS_REGS));

endmodule

`default_nettype wire

// ==== rename/renameMap.sv ====
`timescale 1ns/100ps
`default_nettype none

module renameMap (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               inValid,
    input  pipePkg::decodedBundle              inBundle,
    output logic                               inReady,
    output logic                               outValid,
    output pipePkg::renamedBundle              outBundle,
    input  logic                               outReady,
    input  logic [$clog2(pipePkg::PHYS_REGS):0] freeCount,
    input  pipePkg::physTag                    freeHead0,
    input  pipePkg::physTag                    freeHead1,
    output logic [1:0]                         popCount
);
    import isaPkg::*;
    import pipePkg::*;

    physTag mapTable [ARCH_REGS];
    logic wr0, wr1;
    logic [1:0] needCount;
    logic enough, fire;
    physTag pd0, pd1;

    assign wr0 = inBundle[0].valid & inBundle[0].writesDest;
    assign wr1 = inBundle[1].valid & inBundle[1].writesDest;
    assign needCount = 2'(wr0) + 2'(wr1);
    assign enough = freeCount >= {3'b000, needCount};

    // the bundle waits in stage1 until every destination can get a tag
    assign inReady = outReady & enough;
    assign outValid = inValid & enough;
    assign fire = inValid & inReady;
    assign popCount = fire ? needCount : 2'd0;

    // tags come off the head in slot order
    assign pd0 = wr0 ? freeHead0 : '0;
    assign pd1 = wr1 ? (wr0 ? freeHead1 : freeHead0) : '0;

    // ********************
    // source lookup
    // ********************
    always_comb begin
        outBundle[0].valid = inBundle[0].valid;
        outBundle[0].op = inBundle[0].op;
        outBundle[0].pd = pd0;
        outBundle[0].ps1 = mapTable[inBundle[0].rs1];
        outBundle[0].ps2 = mapTable[inBundle[0].rs2];

        outBundle[1].valid = inBundle[1].valid;
        outBundle[1].op = inBundle[1].op;
        outBundle[1].pd = pd1;
        // slot 1 sees slot 0's result before the table does
        outBundle[1].ps1 = (wr0 && inBundle[1].rs1 == inBundle[0].rd) ? pd0
                                                                       : mapTable[inBundle[1].rs1];
        outBundle[1].ps2 = (wr0 && inBundle[1].rs2 == inBundle[0].rd) ? pd0
                                                                       : mapTable[inBundle[1].rs2];
    end

    // ********************
    // map table update
    // ********************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                mapTable[i] <= physTag'(i);  // identity mapping
            end
        end else if (fire) begin
            if (wr0) begin
                mapTable[inBundle[0].rd] <= pd0;
            end
            if (wr1) begin
                mapTable[inBundle[1].rd] <= pd1;  // wins over slot 0 on the same rd
            end
        end
    end

    // the pop must be covered by what the free list reports
    popWithinFree: assert property (@(posedge clk) disable iff (!rstN)
        popCount <= freeCount);

endmodule

`default_nettype wire

// ==== verif/frontEndTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module frontEndTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam string DATA_FILE = "verif/frontEndTestdata.txt";
    localparam int DRAIN_LIMIT = 40;  // cycles a test may take to empty the pipeline

    logic clk = 1'b0;
    logic rstN, flush, inValid, inReady, outValid, outReady, relValid;
    rawBundle inBundle;
    renamedBundle outBundle;
    physTag relTag;

    string dataLines[$];
    renamedBundle expQ[$];
    string testName = "";
    int testErrors = 0;
    int passCount = 0;
    int failCount = 0;

    always #20 clk = ~clk;

    frontEnd i_frontEnd (
        .clk       (clk),
        .rstN      (rstN),
        .flush     (flush),
        .inValid   (inValid),
        .inBundle  (inBundle),
        .inReady   (inReady),
        .outValid  (outValid),
        .outBundle (outBundle),
        .outReady  (outReady),
        .relValid  (relValid),
        .relTag    (relTag)
    );

    // ********************
    // stimulus
    // ********************
    task automatic loadData(output logic ok);
        int fd;
        string line;
        fd = $fopen(DATA_FILE, "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    dataLines.push_back(line);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic sendBundle(input logic [1:0] mask, input logic [15:0] w0, input logic [15:0] w1);
        logic accepted;
        inBundle.mask = mask;
        inBundle.instr[0] = w0;
        inBundle.instr[1] = w1;
        inValid = 1'b1;
        do begin
            @(negedge clk);
            accepted = inReady;  // the transfer happens on the next rising edge
            @(posedge clk);
        end while (!accepted);
        #2 inValid = 1'b0;
    endtask

    task automatic releaseTag(input physTag tag);
        // idle gap so that a bundle ignoring the tag stall surfaces first
        repeat (4) @(posedge clk);
        #2;
        relValid = 1'b1;
        relTag = tag;
        @(posedge clk);
        #2 relValid = 1'b0;
    endtask

    task automatic flushPipe();
        flush = 1'b1;
        @(posedge clk);
        #2 flush = 1'b0;
    endtask

    task automatic holdOutput(input int cycles);
        logic stalled;
        stalled = 1'b0;
        outReady = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (!inReady) begin
                stalled = 1'b1;
            end
            @(posedge clk);
        end
        #2 outReady = 1'b1;
        assert (stalled) else begin
            $display("%0t: inReady never fell while outReady was held low", $time);
            testErrors++;
        end
    endtask

    // ********************
    // checking
    // ********************
    task automatic monitorOutput();
        renamedBundle expected;
        forever begin
            @(negedge clk);
            if (outValid && outReady) begin
                assert (expQ.size() > 0) else begin
                    $display("%0t: extra bundle %h left the front end", $time, outBundle);
                    testErrors++;
                end
                if (expQ.size() > 0) begin
                    expected = expQ.pop_front();
                    assert (outBundle == expected) else begin
                        $display("[FAIL] %0t outBundle expected %h actual %h",
                                 $time, expected, outBundle);
                        testErrors++;
                    end
                end
            end
        end
    endtask

    task automatic finishTest();
        int waited;
        waited = 0;
        while (expQ.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);  // room for bundles that should never come
        #2;
        assert (expQ.size() == 0) else begin
            $display("%0t: %0d expected bundles never arrived", $time, expQ.size());
            testErrors++;
        end
        expQ.delete();
        if (testErrors == 0) begin
            passCount++;
            $display("test %s passed", testName);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", testName, testErrors);
        end
        testErrors = 0;
    endtask

    task automatic runLine(input string line);
        string kind;
        string name;
        int f [9];
        renamedBundle expected;
        void'($sscanf(line, "%s", kind));
        case (kind)
            "T": begin
                void'($sscanf(line, "%s %s", kind, name));
                if (testName != "") begin
                    finishTest();
                end
                testName = name;
            end
            "B": begin
                void'($sscanf(line, "%s %h %h %h", kind, f[0], f[1], f[2]));
                sendBundle(f[0][1:0], f[1][15:0], f[2][15:0]);
            end
            "E": begin
                void'($sscanf(line, "%s %h %h %h %h %h %h %h %h %h", kind,
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]));
                for (int s = 0; s < MACHINE_WIDTH; s++) begin
                    expected[s].valid = f[0][s];
                    expected[s].op = opKind'(f[1 + 4 * s][2:0]);
                    expected[s].pd = physTag'(f[2 + 4 * s]);
                    expected[s].ps1 = physTag'(f[3 + 4 * s]);
                    expected[s].ps2 = physTag'(f[4 + 4 * s]);
                end
                expQ.push_back(expected);
            end
            "R": begin
                void'($sscanf(line, "%s %h", kind, f[0]));
                releaseTag(physTag'(f[0]));
            end
            "H": begin
                void'($sscanf(line, "%s %h", kind, f[0]));
                fork
                    holdOutput(f[0]);
                join_none
            end
            "F": flushPipe();
            default: begin
                $display("unknown test data line: %s", line);
                testErrors++;
            end
        endcase
    endtask

    task automatic watchdog(input int lineCount);
        #(lineCount * 40 * 20 + 2000);
        $display("timeout: tests did not finish within %0d ns", lineCount * 800 + 2000);
        $display("TEST FAIL");
        $finish;
    endtask

    initial begin
        logic loaded;
        rstN = 1'b0;
        flush = 1'b0;
        inValid = 1'b0;
        inBundle = '0;
        outReady = 1'b1;
        relValid = 1'b0;
        relTag = '0;
        loadData(loaded);
        if (!loaded || dataLines.size() == 0) begin
            $display("cannot read test data from %s", DATA_FILE);
            $display("TEST FAIL");
            $finish;
        end else begin
            fork
                watchdog(dataLines.size());
            join_none
            repeat (5) @(posedge clk);
            #2 rstN = 1'b1;
            assert (inReady && !outValid) else begin
                $display("%0t: front end not idle and ready after reset", $time);
                testErrors++;
            end
            fork
                monitorOutput();
            join_none
            foreach (dataLines[i]) begin
                runLine(dataLines[i]);
            end
            finishTest();
            $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
            if (failCount == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verif/frontEndTestdata.txt ====
# T name | B mask word0 word1 | E mask op0 pd0 ps1 ps2 op1 pd1 ps1 ps2 (expected, in order)
# R tag | H cycles | F (flush); all numbers are hex
T decode
B 3 0298 1528
E 3 0 8 2 3 1 9 4 5
B 3 2650 3970
E 3 2 a 8 9 3 b 5 6
B 3 4a00 92e0
E 3 4 c 0 0 6 0 a b
T dependency
B 3 0e50 1fd8
E 3 0 d 8 9 1 e d a
B 1 33f8 5000
E 1 3 f e e 5 0 0 0
T exhaustion
B 3 0478 4600
R 5
R 2
E 3 0 5 f e 4 2 0 0
T backpressure
R 3
R 4
H 8
E 1 0 3 5 2 6 0 0 0
E 1 1 4 3 0 5 0 0 0
E 1 5 0 4 3 5 0 0 0
B 1 0898 f000
B 1 1d00 5000
B 1 51a0 5000
T flush
R 7
R 8
H 10
E 1 2 7 4 3 5 0 0 0
E 1 4 8 0 0 5 0 0 0
B 1 2ba0 5000
B 1 3368 5000
F
B 1 4400 5000
